/* exec_defs.svh */
/*
  Sizing macros for the execute stage: datapath width, register and
  completion-buffer counts, result queue depth and unit latencies.
*/
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// datapath
`define EXEC_XLEN        32
`define EXEC_NUM_REGS    32

// completion buffer and result queue, queue depth a power of two
`define EXEC_CB_ENTRIES  16
`define EXEC_RQ_DEPTH    8

// unit latencies in cycles from go to result
`define EXEC_MUL_STAGES  3
`define EXEC_DIV_CYCLES  33

`endif

/* exec_isa_pkg.sv */
/*
  Instruction-level types shared by the execute units and the testbench:
  data word, register index, operation and exception codes.
*/
`include "exec_defs.svh"

package exec_isa_pkg;

  typedef logic [`EXEC_XLEN-1:0] word_t;
  typedef logic [$clog2(`EXEC_NUM_REGS)-1:0] reg_idx_t;

  // operations the execute stage knows about
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
    OP_JAL, OP_JALR,
    OP_MUL, OP_MULHU,
    OP_DIVU, OP_REMU
  } exec_op_t;

  typedef enum logic {
    NO_EXCEPTION,
    MAL_TARGET
  } exc_t;

endpackage

/* exec_pipe_pkg.sv */
/*
  Pipeline types for the execute stage: issue and result packets,
  redirect, unit select and the FSM state encodings.
*/
`include "exec_defs.svh"

package exec_pipe_pkg;

  typedef logic [$clog2(`EXEC_CB_ENTRIES)-1:0] cb_idx_t;
  // occupancy and credit counts, 0 up to the full queue depth
  typedef logic [$clog2(`EXEC_RQ_DEPTH+1)-1:0] rq_count_t;

  typedef enum logic [1:0] {
    FU_ALU,
    FU_MUL,
    FU_DIV
  } fu_t;

  typedef struct packed {
    exec_isa_pkg::exec_op_t op;
    exec_isa_pkg::word_t    rs1_data;
    exec_isa_pkg::word_t    rs2_data;
    exec_isa_pkg::word_t    imm;
    exec_isa_pkg::word_t    pc;
    logic                   prediction;
    exec_isa_pkg::reg_idx_t rd;
    cb_idx_t                cb_idx;
  } issue_t;

  typedef struct packed {
    cb_idx_t                cb_idx;
    exec_isa_pkg::reg_idx_t rd;
    exec_isa_pkg::word_t    wdata;
    logic                   wen;
    exec_isa_pkg::exc_t     exc;
  } result_t;

  typedef struct packed {
    logic                valid;
    exec_isa_pkg::word_t target;
  } redirect_t;

  typedef enum logic {DIV_IDLE, DIV_RUN} div_state_t;
  typedef enum logic [1:0] {WB_IDLE, WB_REQ, WB_WAIT_LOW} wb_state_t;

endpackage

/* issue_dispatch.sv */
/*
  Issue side of the execute stage. Runs the four-phase issue handshake,
  picks the unit for each operation and holds back acceptance when the
  result queue could not absorb every result already in flight.
*/
`timescale 1ns/1ns

module issue_dispatch (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     issue_req,
  input  exec_pipe_pkg::issue_t    issue_pkt,
  input  logic                     div_busy,
  input  exec_pipe_pkg::rq_count_t free_count,
  input  logic [1:0]               retire_count,
  output logic                     issue_ack,
  output logic                     alu_go,
  output logic                     mul_go,
  output logic                     div_go,
  output exec_pipe_pkg::issue_t    op_pkt
);

  import exec_isa_pkg::*;
  import exec_pipe_pkg::*;

  fu_t       unit;
  rq_count_t in_flight;
  logic      can_take;
  logic      accept;

  function automatic fu_t unit_of(exec_op_t op);
    case (op)
      OP_MUL, OP_MULHU: unit_of = FU_MUL;
      OP_DIVU, OP_REMU: unit_of = FU_DIV;
      default:          unit_of = FU_ALU;
    endcase
  endfunction

  assign unit = unit_of(issue_pkt.op);

  // every result in flight must already own a free queue slot
  assign can_take = (in_flight < free_count) && !((unit == FU_DIV) && div_busy);
  assign accept   = issue_req && !issue_ack && can_take;

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      issue_ack <= 1'b0;
      alu_go    <= 1'b0;
      mul_go    <= 1'b0;
      div_go    <= 1'b0;
      in_flight <= '0;
    end else begin
      alu_go <= accept && (unit == FU_ALU);
      mul_go <= accept && (unit == FU_MUL);
      div_go <= accept && (unit == FU_DIV);
      // ack drops on the first edge that sees req low
      if (accept)
        issue_ack <= 1'b1;
      else if (!issue_req)
        issue_ack <= 1'b0;
      in_flight <= in_flight + rq_count_t'(accept) - rq_count_t'(retire_count);
    end
  end

  // one packet register shared by all three units
  always_ff @(posedge CLK) begin
    if (accept)
      op_pkt <= issue_pkt;
  end

endmodule

/* alu_branch_unit.sv */
/*
  Single-cycle integer ALU with branch and jump resolution. Produces the
  result one cycle after go, together with a redirect when the path
  changes. Misaligned targets come back as MAL_TARGET carrying the pc.
*/
`timescale 1ns/1ns
`include "exec_defs.svh"

module alu_branch_unit (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     alu_go,
  input  exec_pipe_pkg::issue_t    op_pkt,
  output exec_pipe_pkg::result_t   alu_res,
  output logic                     alu_valid,
  output exec_pipe_pkg::redirect_t redirect
);

  import exec_isa_pkg::*;
  import exec_pipe_pkg::*;

  localparam int SHAMT_W = $clog2(`EXEC_XLEN);

  word_t   a, b, alu_out;
  word_t   pc4, br_target, jalr_sum, jump_target, next_pc;
  logic    is_branch, is_jump, taken, mal;
  result_t res_next;
  logic    redir_valid;

  assign a = op_pkt.rs1_data;
  assign b = op_pkt.rs2_data;

  always_comb begin
    case (op_pkt.op)
      OP_ADD:  alu_out = a + b;
      OP_SUB:  alu_out = a - b;
      OP_AND:  alu_out = a & b;
      OP_OR:   alu_out = a | b;
      OP_XOR:  alu_out = a ^ b;
      OP_SLT:  alu_out = word_t'($signed(a) < $signed(b));
      OP_SLTU: alu_out = word_t'(a < b);
      OP_SLL:  alu_out = a << b[SHAMT_W-1:0];
      OP_SRL:  alu_out = a >> b[SHAMT_W-1:0];
      OP_SRA:  alu_out = word_t'($signed(a) >>> b[SHAMT_W-1:0]);
      default: alu_out = '0;
    endcase
  end

  // branch compare
  always_comb begin
    case (op_pkt.op)
      OP_BEQ:  taken = (a == b);
      OP_BNE:  taken = (a != b);
      OP_BLT:  taken = ($signed(a) < $signed(b));
      OP_BGE:  taken = ($signed(a) >= $signed(b));
      default: taken = 1'b0;
    endcase
  end

  assign is_branch = op_pkt.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE};
  assign is_jump   = op_pkt.op inside {OP_JAL, OP_JALR};

  assign pc4         = op_pkt.pc + 4;
  assign br_target   = op_pkt.pc + op_pkt.imm;
  assign jalr_sum    = a + op_pkt.imm;
  // jalr clears bit 0 of its target
  assign jump_target = (op_pkt.op == OP_JALR) ? {jalr_sum[`EXEC_XLEN-1:1], 1'b0} : br_target;
  assign next_pc     = is_jump ? jump_target : (taken ? br_target : pc4);
  assign mal         = (is_branch || is_jump) && (next_pc[1:0] != 2'b00);

  always_comb begin
    res_next.cb_idx = op_pkt.cb_idx;
    res_next.rd     = op_pkt.rd;
    res_next.exc    = NO_EXCEPTION;
    if (mal) begin
      res_next.wdata = op_pkt.pc;
      res_next.wen   = 1'b0;
      res_next.exc   = MAL_TARGET;
    end else if (is_branch) begin
      // branches report where the path really goes
      res_next.wdata = next_pc;
      res_next.wen   = 1'b0;
    end else if (is_jump) begin
      res_next.wdata = pc4;
      res_next.wen   = 1'b1;
    end else begin
      res_next.wdata = alu_out;
      res_next.wen   = 1'b1;
    end
  end

  assign redir_valid = !mal && (is_jump || (is_branch && (taken != op_pkt.prediction)));

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      alu_valid <= 1'b0;
      redirect  <= '0;
    end else begin
      alu_valid <= alu_go;
      redirect  <= '{valid: alu_go && redir_valid, target: next_pc};
    end
  end

  always_ff @(posedge CLK) begin
    if (alu_go)
      alu_res <= res_next;
  end

endmodule

/* multiply_pipe.sv */
/*
  Three-stage unsigned multiplier. A new multiply may enter every cycle;
  the valid flag and tag shift along a delay line beside the product.
*/
`timescale 1ns/1ns
`include "exec_defs.svh"

module multiply_pipe (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   mul_go,
  input  exec_pipe_pkg::issue_t  op_pkt,
  output exec_pipe_pkg::result_t mul_res,
  output logic                   mul_valid
);

  import exec_isa_pkg::*;
  import exec_pipe_pkg::*;

  localparam int LAST = `EXEC_MUL_STAGES - 1;

  typedef struct packed {
    cb_idx_t  cb_idx;
    reg_idx_t rd;
    logic     high;
  } mul_tag_t;

  logic [LAST:0]             vld_q;
  mul_tag_t                  tag_q [`EXEC_MUL_STAGES];
  word_t                     a_q, b_q;
  logic [2*`EXEC_XLEN-1:0]   prod_q;
  word_t                     wdata_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST)
      vld_q <= '0;
    else
      vld_q <= {vld_q[LAST-1:0], mul_go};
  end

  always_ff @(posedge CLK) begin
    tag_q[0] <= '{cb_idx: op_pkt.cb_idx, rd: op_pkt.rd, high: op_pkt.op == OP_MULHU};
    for (int i = 1; i < `EXEC_MUL_STAGES; i++)
      tag_q[i] <= tag_q[i-1];
    // stage 1 operands, stage 2 full product, stage 3 half select
    a_q     <= op_pkt.rs1_data;
    b_q     <= op_pkt.rs2_data;
    prod_q  <= {{`EXEC_XLEN{1'b0}}, a_q} * {{`EXEC_XLEN{1'b0}}, b_q};
    wdata_q <= tag_q[LAST-1].high ? prod_q[2*`EXEC_XLEN-1:`EXEC_XLEN]
                                  : prod_q[`EXEC_XLEN-1:0];
  end

  assign mul_valid = vld_q[LAST];
  assign mul_res   = '{cb_idx: tag_q[LAST].cb_idx,
                       rd:     tag_q[LAST].rd,
                       wdata:  wdata_q,
                       wen:    1'b1,
                       exc:    NO_EXCEPTION};

endmodule

/* divide_unit.sv */
/*
  Iterative restoring unsigned divider. Loads on go, then runs one
  quotient bit per cycle; the result appears 33 cycles after go.
  Division by zero naturally gives all ones and the dividend back.
*/
`timescale 1ns/1ns
`include "exec_defs.svh"

module divide_unit (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   div_go,
  input  exec_pipe_pkg::issue_t  op_pkt,
  output exec_pipe_pkg::result_t div_res,
  output logic                   div_valid,
  output logic                   div_busy
);

  import exec_isa_pkg::*;
  import exec_pipe_pkg::*;

  localparam int XLEN  = `EXEC_XLEN;
  localparam int CNT_W = $clog2(`EXEC_DIV_CYCLES);

  typedef logic [CNT_W-1:0] cnt_t;

  div_state_t      state;
  cnt_t            count;
  word_t           quo_q, rem_q, dsr_q;
  cb_idx_t         cb_q;
  reg_idx_t        rd_q;
  logic            want_rem_q;
  logic [XLEN:0]   shifted, diff;

  // one restoring step: shift in the next dividend bit and try a subtract
  assign shifted = {rem_q, quo_q[XLEN-1]};
  assign diff    = shifted - {1'b0, dsr_q};

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      state     <= DIV_IDLE;
      count     <= '0;
      div_valid <= 1'b0;
    end else begin
      div_valid <= 1'b0;
      case (state)
        DIV_IDLE: begin
          if (div_go) begin
            state <= DIV_RUN;
            count <= cnt_t'(`EXEC_DIV_CYCLES - 1);
          end
        end
        DIV_RUN: begin
          count <= count - 1'b1;
          // last iteration, result shows next cycle
          if (count == cnt_t'(1)) begin
            state     <= DIV_IDLE;
            div_valid <= 1'b1;
          end
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if ((state == DIV_IDLE) && div_go) begin
      quo_q      <= op_pkt.rs1_data;
      rem_q      <= '0;
      dsr_q      <= op_pkt.rs2_data;
      // tag stays put until the next load
      cb_q       <= op_pkt.cb_idx;
      rd_q       <= op_pkt.rd;
      want_rem_q <= (op_pkt.op == OP_REMU);
    end else if (state == DIV_RUN) begin
      if (!diff[XLEN]) begin
        rem_q <= diff[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= shifted[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  assign div_busy = div_go || (state == DIV_RUN);
  assign div_res  = '{cb_idx: cb_q,
                      rd:     rd_q,
                      wdata:  want_rem_q ? rem_q : quo_q,
                      wen:    1'b1,
                      exc:    NO_EXCEPTION};

endmodule

/* result_queue.sv */
/*
  Result FIFO between the execute units and the writeback port. Takes up
  to three results per cycle in ALU, MUL, DIV order and gives one back.
  retire_count reports how many results are written this cycle.
*/
`timescale 1ns/1ns
`include "exec_defs.svh"

module result_queue (
  input  logic                     CLK,
  input  logic                     nRST,
  input  exec_pipe_pkg::result_t   alu_res,
  input  logic                     alu_valid,
  input  exec_pipe_pkg::result_t   mul_res,
  input  logic                     mul_valid,
  input  exec_pipe_pkg::result_t   div_res,
  input  logic                     div_valid,
  input  logic                     pop,
  output exec_pipe_pkg::result_t   head,
  output logic                     empty,
  output exec_pipe_pkg::rq_count_t free_count,
  output logic [1:0]               retire_count
);

  import exec_pipe_pkg::*;

  localparam int PTR_W = $clog2(`EXEC_RQ_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  result_t   mem [`EXEC_RQ_DEPTH];
  ptr_t      wr_ptr, rd_ptr;
  ptr_t      mul_slot, div_slot;
  rq_count_t count;
  logic [1:0] n_wr;

  // later ports land behind the earlier ones in the same cycle
  assign mul_slot = wr_ptr + ptr_t'(alu_valid);
  assign div_slot = mul_slot + ptr_t'(mul_valid);
  assign n_wr     = 2'(alu_valid) + 2'(mul_valid) + 2'(div_valid);

  always_ff @(posedge CLK) begin
    if (alu_valid)
      mem[wr_ptr] <= alu_res;
    if (mul_valid)
      mem[mul_slot] <= mul_res;
    if (div_valid)
      mem[div_slot] <= div_res;
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + ptr_t'(n_wr);
      rd_ptr <= rd_ptr + ptr_t'(pop);
      count  <= count + rq_count_t'(n_wr) - rq_count_t'(pop);
    end
  end

  assign head         = mem[rd_ptr];
  assign empty        = (count == '0);
  assign free_count   = rq_count_t'(`EXEC_RQ_DEPTH) - count;
  assign retire_count = n_wr;

endmodule

/* writeback_port.sv */
/*
  Drains the result queue onto the completion buffer, one result per
  four-phase req/ack exchange. wb_result holds still until ack arrives.
*/
`timescale 1ns/1ns

module writeback_port (
  input  logic                   CLK,
  input  logic                   nRST,
  input  exec_pipe_pkg::result_t head,
  input  logic                   empty,
  input  logic                   wb_ack,
  output logic                   pop,
  output logic                   wb_req,
  output exec_pipe_pkg::result_t wb_result
);

  import exec_pipe_pkg::*;

  wb_state_t state;

  assign pop    = (state == WB_IDLE) && !empty;
  assign wb_req = (state == WB_REQ);

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      state <= WB_IDLE;
    end else begin
      case (state)
        WB_IDLE:     if (!empty) state <= WB_REQ;
        WB_REQ:      if (wb_ack) state <= WB_WAIT_LOW;
        // ack must fall before the next result goes out
        WB_WAIT_LOW: if (!wb_ack) state <= WB_IDLE;
        default:     state <= WB_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (pop)
      wb_result <= head;
  end

endmodule

/* ooo_execute_stage.sv */
/*
  Execute stage top level. Issue dispatch feeds the ALU, multiplier and
  divider; their results meet in the result queue and leave through the
  writeback port. Redirects come straight from the ALU.
*/
`timescale 1ns/1ns

module ooo_execute_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     issue_req,
  input  exec_pipe_pkg::issue_t    issue_pkt,
  input  logic                     wb_ack,
  output logic                     issue_ack,
  output logic                     wb_req,
  output exec_pipe_pkg::result_t   wb_result,
  output exec_pipe_pkg::redirect_t redirect
);

  import exec_pipe_pkg::*;

  issue_t     op_pkt;
  logic       alu_go, mul_go, div_go;
  logic       div_busy;
  result_t    alu_res, mul_res, div_res, head;
  logic       alu_valid, mul_valid, div_valid;
  logic       empty, pop;
  rq_count_t  free_count;
  logic [1:0] retire_count;

  issue_dispatch issue_dispatch_inst (
    .CLK(CLK), .nRST(nRST),
    .issue_req(issue_req), .issue_pkt(issue_pkt),
    .div_busy(div_busy), .free_count(free_count), .retire_count(retire_count),
    .issue_ack(issue_ack),
    .alu_go(alu_go), .mul_go(mul_go), .div_go(div_go),
    .op_pkt(op_pkt)
  );

  alu_branch_unit alu_branch_unit_inst (
    .CLK(CLK), .nRST(nRST),
    .alu_go(alu_go), .op_pkt(op_pkt),
    .alu_res(alu_res), .alu_valid(alu_valid), .redirect(redirect)
  );

  multiply_pipe multiply_pipe_inst (
    .CLK(CLK), .nRST(nRST),
    .mul_go(mul_go), .op_pkt(op_pkt),
    .mul_res(mul_res), .mul_valid(mul_valid)
  );

  divide_unit divide_unit_inst (
    .CLK(CLK), .nRST(nRST),
    .div_go(div_go), .op_pkt(op_pkt),
    .div_res(div_res), .div_valid(div_valid), .div_busy(div_busy)
  );

  // fixed priority ALU, MUL, DIV when several finish together
  result_queue result_queue_inst (
    .CLK(CLK), .nRST(nRST),
    .alu_res(alu_res), .alu_valid(alu_valid),
    .mul_res(mul_res), .mul_valid(mul_valid),
    .div_res(div_res), .div_valid(div_valid),
    .pop(pop),
    .head(head), .empty(empty),
    .free_count(free_count), .retire_count(retire_count)
  );

  writeback_port writeback_port_inst (
    .CLK(CLK), .nRST(nRST),
    .head(head), .empty(empty), .wb_ack(wb_ack),
    .pop(pop), .wb_req(wb_req), .wb_result(wb_result)
  );

endmodule

/* exec_props.sv */
/*
  Handshake and result queue assertions, bound into the execute stage
  top level so they watch the live issue and writeback ports.
*/
`timescale 1ns/1ns
`include "exec_defs.svh"

module exec_props (
  input logic                     CLK,
  input logic                     nRST,
  input logic                     issue_req,
  input logic                     issue_ack,
  input logic                     wb_req,
  input logic                     wb_ack,
  input exec_pipe_pkg::result_t   wb_result,
  input exec_pipe_pkg::rq_count_t free_count
);

  import exec_isa_pkg::*;
  import exec_pipe_pkg::*;

  // request and payload hold until the completion buffer answers
  assert property (@(posedge CLK) disable iff (!nRST)
    (wb_req && !wb_ack) |=> (wb_req && $stable(wb_result)))
    else $error("wb_req or wb_result changed before wb_ack");

  assert property (@(posedge CLK) disable iff (!nRST)
    (wb_req && wb_ack) |=> !wb_req)
    else $error("wb_req still high after wb_ack");

  // ack only ever answers a request
  assert property (@(posedge CLK) disable iff (!nRST)
    (!issue_req && !issue_ack) |=> !issue_ack)
    else $error("issue_ack rose while issue_req was low");

  assert property (@(posedge CLK) disable iff (!nRST)
    (issue_ack && !issue_req) |=> !issue_ack)
    else $error("issue_ack stayed high after issue_req fell");

  assert property (@(posedge CLK) disable iff (!nRST)
    free_count <= rq_count_t'(`EXEC_RQ_DEPTH))
    else $error("result queue free count above its depth");

endmodule

bind ooo_execute_stage exec_props exec_props_inst (
  .CLK(CLK), .nRST(nRST),
  .issue_req(issue_req), .issue_ack(issue_ack),
  .wb_req(wb_req), .wb_ack(wb_ack), .wb_result(wb_result),
  .free_count(free_count)
);

/* tb_ooo_execute_stage.sv */
/*
  Testbench for the execute stage. Issues random instructions over the
  issue handshake and answers writeback after random delays. Each result
  and redirect is checked against a behavioral model.
*/
`timescale 1ns/1ns
`include "exec_defs.svh"

module tb_ooo_execute_stage;

  import exec_isa_pkg::*;
  import exec_pipe_pkg::*;

  localparam int SEED       = 18923;
  localparam int NUM_TESTS  = 300;
  localparam int MAX_CYCLES = NUM_TESTS * 60;

  logic      CLK = 1'b0;
  logic      nRST;
  logic      issue_req;
  issue_t    issue_pkt;
  logic      wb_ack;
  logic      issue_ack;
  logic      wb_req;
  result_t   wb_result;
  redirect_t redirect;

  // expected result per completion-buffer slot
  result_t   expected [`EXEC_CB_ENTRIES];
  int        issue_cnt [`EXEC_CB_ENTRIES];
  int        done_cnt [`EXEC_CB_ENTRIES];
  redirect_t exp_redirects [$];
  int        redirect_idx;
  int        received;
  int        result_errors;
  int        redirect_errors;
  int        other_errors;
  int        cycle_count;

  always #4 CLK = ~CLK;

  ooo_execute_stage ooo_execute_stage_inst (
    .CLK(CLK), .nRST(nRST),
    .issue_req(issue_req), .issue_pkt(issue_pkt), .wb_ack(wb_ack),
    .issue_ack(issue_ack), .wb_req(wb_req), .wb_result(wb_result),
    .redirect(redirect)
  );

  function automatic issue_t make_instr(input int n);
    issue_t      p;
    logic [11:0] imm12;
    p.op = exec_op_t'(5'($urandom_range(19, 0)));
    p.rs1_data = $urandom;
    if ($urandom_range(1, 0) == 0)
      p.rs1_data[1:0] = 2'b00;
    // equal and tiny operands reach the compare, shift and divide corners
    case ($urandom_range(3, 0))
      0:       p.rs2_data = p.rs1_data;
      1:       p.rs2_data = word_t'($urandom_range(3, 0));
      default: p.rs2_data = $urandom;
    endcase
    imm12 = 12'($urandom_range(4095, 0));
    p.imm = {{20{imm12[11]}}, imm12[11:2], 2'b00};
    // now and then an offset that breaks alignment
    if ($urandom_range(7, 0) == 0)
      p.imm[1:0] = 2'($urandom_range(3, 1));
    p.pc = $urandom & 32'hFFFF_FFFC;
    p.prediction = 1'($urandom_range(1, 0));
    p.rd = reg_idx_t'($urandom_range(`EXEC_NUM_REGS - 1, 0));
    p.cb_idx = cb_idx_t'(n % `EXEC_CB_ENTRIES);
    return p;
  endfunction

  // architectural behavior of one instruction
  function automatic void model_instr(input issue_t p, output result_t r,
                                      output redirect_t d);
    word_t       a;
    word_t       b;
    word_t       npc;
    logic [63:0] prod;
    logic        taken;
    logic        ctrl;
    a = p.rs1_data;
    b = p.rs2_data;
    prod = 64'(a) * 64'(b);
    taken = 1'b0;
    npc = p.pc + 32'd4;
    ctrl = p.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JAL, OP_JALR};
    r = '{cb_idx: p.cb_idx, rd: p.rd, wdata: '0, wen: 1'b1, exc: NO_EXCEPTION};
    d = '0;
    case (p.op)
      OP_ADD:   r.wdata = a + b;
      OP_SUB:   r.wdata = a - b;
      OP_AND:   r.wdata = a & b;
      OP_OR:    r.wdata = a | b;
      OP_XOR:   r.wdata = a ^ b;
      OP_SLT:   r.wdata = {31'b0, $signed(a) < $signed(b)};
      OP_SLTU:  r.wdata = {31'b0, a < b};
      OP_SLL:   r.wdata = a << b[4:0];
      OP_SRL:   r.wdata = a >> b[4:0];
      OP_SRA:   r.wdata = $signed(a) >>> b[4:0];
      OP_BEQ:   taken = (a == b);
      OP_BNE:   taken = (a != b);
      OP_BLT:   taken = ($signed(a) < $signed(b));
      OP_BGE:   taken = ($signed(a) >= $signed(b));
      OP_JAL:   npc = p.pc + p.imm;
      OP_JALR:  npc = (a + p.imm) & ~32'd1;
      OP_MUL:   r.wdata = prod[31:0];
      OP_MULHU: r.wdata = prod[63:32];
      OP_DIVU:  r.wdata = (b == 0) ? 32'hFFFF_FFFF : a / b;
      OP_REMU:  r.wdata = (b == 0) ? a : a % b;
      default:  r.wdata = '0;
    endcase
    if (p.op inside {OP_JAL, OP_JALR}) begin
      r.wdata = p.pc + 32'd4;
      d = '{valid: 1'b1, target: npc};
    end else if (ctrl) begin
      if (taken)
        npc = p.pc + p.imm;
      r.wdata = npc;
      r.wen = 1'b0;
      d = '{valid: taken != p.prediction, target: npc};
    end
    // a misaligned target reports the pc and stays on the path
    if (ctrl && (npc[1:0] != 2'b00)) begin
      r.wdata = p.pc;
      r.wen = 1'b0;
      r.exc = MAL_TARGET;
      d = '0;
    end
  endfunction

  task automatic check_result(input result_t got, input result_t exp);
    if (got !== exp) begin
      result_errors++;
      $display("[ERROR] %0t: cb %0d rd/wdata/wen/exc %0d/%h/%b/%0d, expected %0d/%h/%b/%0d",
               $time, got.cb_idx, got.rd, got.wdata, got.wen, got.exc,
               exp.rd, exp.wdata, exp.wen, exp.exc);
    end
  endtask

  task automatic check_redirect(input redirect_t got, input redirect_t exp);
    if (got !== exp) begin
      redirect_errors++;
      $display("[ERROR] %0t: redirect got valid %b target %h, expected valid %b target %h",
               $time, got.valid, got.target, exp.valid, exp.target);
    end
  endtask

  task automatic issue_instr(input issue_t pkt);
    issue_req = 1'b1;
    issue_pkt = pkt;
    do @(negedge CLK); while (!issue_ack);
    issue_req = 1'b0;
    do @(negedge CLK); while (issue_ack);
  endtask

  task automatic take_result(input result_t got);
    if (issue_cnt[got.cb_idx] == done_cnt[got.cb_idx]) begin
      result_errors++;
      $display("writeback for cb_idx %0d which had no instruction outstanding", got.cb_idx);
    end else begin
      check_result(got, expected[got.cb_idx]);
      done_cnt[got.cb_idx]++;
    end
    received++;
  endtask

  initial begin
    issue_t    pkt;
    result_t   exp_r;
    redirect_t exp_d;
    int        i;
    int        k;
    void'($urandom(SEED));
    nRST = 1'b0;
    issue_req = 1'b0;
    issue_pkt = '0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);
    if (issue_ack || wb_req || redirect.valid) begin
      other_errors++;
      $display("[ERROR] %0t: issue_ack %b wb_req %b redirect valid %b after reset, expected low",
               $time, issue_ack, wb_req, redirect.valid);
    end
    for (i = 0; i < NUM_TESTS; i++) begin
      pkt = make_instr(i);
      // slot still owned by an earlier instruction
      while (issue_cnt[pkt.cb_idx] != done_cnt[pkt.cb_idx])
        @(negedge CLK);
      model_instr(pkt, exp_r, exp_d);
      expected[pkt.cb_idx] = exp_r;
      issue_cnt[pkt.cb_idx]++;
      if (exp_d.valid)
        exp_redirects.push_back(exp_d);
      issue_instr(pkt);
    end
    while (received < NUM_TESTS)
      @(negedge CLK);
    repeat (4) @(negedge CLK);
    for (k = 0; k < `EXEC_CB_ENTRIES; k++) begin
      if (issue_cnt[k] != done_cnt[k]) begin
        other_errors++;
        $display("instruction with cb_idx %0d never came back on writeback", k);
      end
    end
    if (redirect_idx != exp_redirects.size()) begin
      other_errors++;
      $display("%0d expected redirects never appeared", exp_redirects.size() - redirect_idx);
    end
    $display("errors: %0d result, %0d redirect, %0d other; %0d results, %0d redirects checked",
             result_errors, redirect_errors, other_errors, received, redirect_idx);
    if (result_errors + redirect_errors + other_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // completion-buffer side of the writeback handshake
  initial begin
    int hold;
    wb_ack = 1'b0;
    forever begin
      @(negedge CLK);
      if (wb_req && !wb_ack) begin
        take_result(wb_result);
        // every 40th result a long hold lets the queue fill and stall issue
        hold = (received % 40 == 0) ? 30 : int'($urandom_range(3, 0));
        repeat (hold) @(negedge CLK);
        wb_ack = 1'b1;
        do @(negedge CLK); while (wb_req);
        wb_ack = 1'b0;
      end
    end
  end

  always @(negedge CLK) begin
    if (nRST && redirect.valid) begin
      if (redirect_idx >= exp_redirects.size()) begin
        redirect_errors++;
        $display("redirect to %h appeared when no redirect was expected", redirect.target);
      end else begin
        check_redirect(redirect, exp_redirects[redirect_idx]);
      end
      redirect_idx++;
    end
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d results back",
               cycle_count, received, NUM_TESTS);
      $display("STATUS: FAIL");
      $finish;
    end
  end

endmodule

/* project.f */
+incdir+.
exec_isa_pkg.sv
exec_pipe_pkg.sv
issue_dispatch.sv
alu_branch_unit.sv
multiply_pipe.sv
divide_unit.sv
result_queue.sv
writeback_port.sv
ooo_execute_stage.sv
exec_props.sv
tb_ooo_execute_stage.sv

/* Makefile */
# Verilator flow for the execute stage testbench
# override any variable on the command line, e.g. make LOG=run.log

TOP       ?= tb_ooo_execute_stage
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
